// File: common/AESDefinitions.sv
// Shared AES types, round count and byte-level helpers
// Every module of the cipher core takes this package by wildcard import

package AESDefinitions;

  typedef logic [7:0] byte_t;

  // Column-major, byte k sits at row k % 4 and column k / 4
  typedef byte_t [0:15] state_t;
  typedef byte_t [0:15] roundKey_t;

  function automatic int numRounds(int keySize);
    case (keySize)
      256: return 14;
      192: return 12;
      default: return 10;
    endcase
  endfunction

  // Forward S-box, one row of 16 entries per line
  localparam logic [0:2047] SBOX_TABLE = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  localparam logic [0:2047] INV_SBOX_TABLE = {
    128'h52096ad53036a538bf40a39e81f3d7fb,
    128'h7ce339829b2fff87348e4344c4dee9cb,
    128'h547b9432a6c2233dee4c950b42fac34e,
    128'h082ea16628d924b2765ba2496d8bd125,
    128'h72f8f66486689816d4a45ccc5d65b692,
    128'h6c704850fdedb9da5e154657a78d9d84,
    128'h90d8ab008cbcd30af7e45805b8b34506,
    128'hd02c1e8fca3f0f02c1afbd0301138a6b,
    128'h3a9111414f67dcea97f2cfcef0b4e673,
    128'h96ac7422e7ad3585e2f937e81c75df6e,
    128'h47f11a711d29c5896fb7620eaa18be1b,
    128'hfc563e4bc6d279209adbc0fe78cd5af4,
    128'h1fdda8338807c731b11210592780ec5f,
    128'h60517fa919b54a0d2de57a9f93c99cef,
    128'ha0e03b4dae2af5b0c8ebbb3c83539961,
    128'h172b047eba77d626e169146355210c7d
  };

  function automatic byte_t sBox(byte_t x);
    return SBOX_TABLE[{x, 3'b000} +: 8];
  endfunction

  function automatic byte_t invSBox(byte_t x);
    return INV_SBOX_TABLE[{x, 3'b000} +: 8];
  endfunction

  // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic byte_t xtime(byte_t b);
    byte_t shifted;
    shifted = {b[6:0], 1'b0};
    if (b[7])
    begin
      shifted = shifted ^ 8'h1b;
    end
    return shifted;
  endfunction

  // Shift-and-add product, one partial term per bit of b
  function automatic byte_t gfMul(byte_t a, byte_t b);
    byte_t product;
    byte_t term;
    product = 8'h00;
    term = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
      begin
        product = product ^ term;
      end
      term = xtime(term);
    end
    return product;
  endfunction

endpackage

// File: keyexpand/ExpandKey.sv
// Combinational AES key schedule for 128, 192 and 256 bit keys
// Produces every round key of one cipher key in a single bundle

`timescale 1ns/1ps

module ExpandKey
  import AESDefinitions::*;
#(
  parameter int KEY_SIZE = 128,
  parameter int NUM_ROUNDS = 10,
  parameter type key_t = byte_t [0:KEY_SIZE/8-1],
  parameter type roundKeys_t = roundKey_t [0:NUM_ROUNDS]
)
(
  input key_t key,
  output roundKeys_t roundKeys
);

  // Key length in words and total schedule length
  localparam int NK = KEY_SIZE / 32;
  localparam int NW = 4 * (NUM_ROUNDS + 1);

  function automatic logic [31:0] subWord(logic [31:0] word);
    return {sBox(word[31:24]), sBox(word[23:16]), sBox(word[15:8]), sBox(word[7:0])};
  endfunction

  always_comb
  begin
    logic [31:0] w [NW];
    logic [31:0] temp;
    byte_t rcon;

    rcon = 8'h01;

    // First NK words come straight from the cipher key
    for (int i = 0; i < NK; i++)
    begin
      w[i] = {key[4*i], key[4*i+1], key[4*i+2], key[4*i+3]};
    end

    for (int i = NK; i < NW; i++)
    begin
      temp = w[i-1];
      if (i % NK == 0)
      begin
        // RotWord, SubWord, then Rcon in the top byte
        temp = subWord({temp[23:0], temp[31:24]}) ^ {rcon, 24'h000000};
        rcon = xtime(rcon);
      end
      else if (NK > 6 && i % NK == 4)
      begin
        // Extra substitution only for 256 bit keys
        temp = subWord(temp);
      end
      w[i] = w[i-NK] ^ temp;
    end

    // Four words per round key, most significant byte first
    for (int r = 0; r <= NUM_ROUNDS; r++)
    begin
      for (int c = 0; c < 4; c++)
      begin
        for (int b = 0; b < 4; b++)
        begin
          roundKeys[r][4*c+b] = w[4*r+c][31-8*b -: 8];
        end
      end
    end
  end

endmodule

// File: rounds/AESRound.sv
// One registered AES round, forward or inverse
// Also carries the round-key bundle one stage down the pipeline

`timescale 1ns/1ps

module AESRound
  import AESDefinitions::*;
#(
  parameter int ROUND = 1,
  parameter int NUM_ROUNDS = 10,
  parameter bit INVERSE = 1'b0,
  parameter type keys_t = roundKey_t [0:NUM_ROUNDS]
)
(
  input logic clock,
  input logic rst,
  input state_t in,
  input roundKey_t roundKey,
  input keys_t keysIn,
  output state_t out,
  output keys_t keysOut
);

  // Last round has no column mixing
  localparam bit LAST = (ROUND == NUM_ROUNDS);

  state_t shifted;
  state_t result;

  function automatic state_t mixColumns(state_t s);
    state_t m;
    for (int c = 0; c < 4; c++)
    begin
      m[4*c]   = xtime(s[4*c]) ^ gfMul(s[4*c+1], 8'h03) ^ s[4*c+2] ^ s[4*c+3];
      m[4*c+1] = s[4*c] ^ xtime(s[4*c+1]) ^ gfMul(s[4*c+2], 8'h03) ^ s[4*c+3];
      m[4*c+2] = s[4*c] ^ s[4*c+1] ^ xtime(s[4*c+2]) ^ gfMul(s[4*c+3], 8'h03);
      m[4*c+3] = gfMul(s[4*c], 8'h03) ^ s[4*c+1] ^ s[4*c+2] ^ xtime(s[4*c+3]);
    end
    return m;
  endfunction

  function automatic state_t invMixColumns(state_t s);
    state_t m;
    for (int c = 0; c < 4; c++)
    begin
      m[4*c]   = gfMul(s[4*c], 8'h0e) ^ gfMul(s[4*c+1], 8'h0b)
               ^ gfMul(s[4*c+2], 8'h0d) ^ gfMul(s[4*c+3], 8'h09);
      m[4*c+1] = gfMul(s[4*c], 8'h09) ^ gfMul(s[4*c+1], 8'h0e)
               ^ gfMul(s[4*c+2], 8'h0b) ^ gfMul(s[4*c+3], 8'h0d);
      m[4*c+2] = gfMul(s[4*c], 8'h0d) ^ gfMul(s[4*c+1], 8'h09)
               ^ gfMul(s[4*c+2], 8'h0e) ^ gfMul(s[4*c+3], 8'h0b);
      m[4*c+3] = gfMul(s[4*c], 8'h0b) ^ gfMul(s[4*c+1], 8'h0d)
               ^ gfMul(s[4*c+2], 8'h09) ^ gfMul(s[4*c+3], 8'h0e);
    end
    return m;
  endfunction

  if (INVERSE)
  begin : genInverse
    always_comb
    begin
      // Row r rotates right by r, then inverse substitution
      for (int c = 0; c < 4; c++)
      begin
        for (int r = 0; r < 4; r++)
        begin
          shifted[r+4*c] = invSBox(in[r+4*((c-r+4)%4)]);
        end
      end
      result = LAST ? (shifted ^ roundKey) : invMixColumns(shifted ^ roundKey);
    end
  end
  else
  begin : genForward
    always_comb
    begin
      // Substitution merged with the left rotation of row r by r
      for (int c = 0; c < 4; c++)
      begin
        for (int r = 0; r < 4; r++)
        begin
          shifted[r+4*c] = sBox(in[r+4*((c+r)%4)]);
        end
      end
      result = (LAST ? shifted : mixColumns(shifted)) ^ roundKey;
    end
  end

  always_ff @(posedge clock)
  begin
    out <= result;
    keysOut <= keysIn;
  end

  // Stage index must fit the chain built by the parent
  roundInRange: assert property (@(posedge clock)
    $fell(rst) |-> (ROUND >= 1 && ROUND <= NUM_ROUNDS))
    else $error("round index %0d outside 1..%0d", ROUND, NUM_ROUNDS);

endmodule

// File: design/FillCounter.sv
// Saturating fill counter behind the round pipeline
// Valid rises once every stage holds data from after reset

`timescale 1ns/1ps

module FillCounter #(
  parameter int NUM_ROUNDS = 10
)
(
  input logic clock,
  input logic rst,
  output logic valid
);

  localparam int WIDTH = $clog2(NUM_ROUNDS + 1);
  localparam logic [WIDTH-1:0] FULL = WIDTH'(NUM_ROUNDS);

  logic [WIDTH-1:0] count;

  always_ff @(posedge clock)
  begin
    if (rst)
      count <= '0;
    else if (count != FULL)
      count <= count + 1'b1;
  end

  assign valid = (count == FULL);

  validHolds: assert property (@(posedge clock) disable iff (rst) valid |=> valid)
    else $error("valid fell without reset");

endmodule

// File: design/AESEncoder.sv
// Fully pipelined AES encryption, one block and key per clock
// Result appears NUM_ROUNDS clocks after its inputs

`timescale 1ns/1ps

module AESEncoder
  import AESDefinitions::*;
#(
  parameter int KEY_SIZE = 128,
  parameter type key_t = byte_t [0:KEY_SIZE/8-1]
)
(
  input logic clock,
  input logic rst,
  input state_t in,
  input key_t key,
  output state_t out,
  output logic valid
);

  localparam int NUM_ROUNDS = numRounds(KEY_SIZE);

  typedef roundKey_t [0:NUM_ROUNDS] roundKeys_t;

  // Entry i feeds stage i+1, last entry is the pipeline output
  state_t stageState [NUM_ROUNDS+1];
  roundKeys_t stageKeys [NUM_ROUNDS+1];

  ExpandKey #(
    .KEY_SIZE(KEY_SIZE),
    .NUM_ROUNDS(NUM_ROUNDS),
    .key_t(key_t),
    .roundKeys_t(roundKeys_t)
  ) keyExpansion (
    .key(key),
    .roundKeys(stageKeys[0])
  );

  // Whitening with round key 0
  assign stageState[0] = in ^ stageKeys[0][0];

  for (genvar i = 1; i <= NUM_ROUNDS; i++)
  begin : genRounds
    AESRound #(
      .ROUND(i),
      .NUM_ROUNDS(NUM_ROUNDS),
      .INVERSE(1'b0),
      .keys_t(roundKeys_t)
    ) round (
      .clock(clock),
      .rst(rst),
      .in(stageState[i-1]),
      .roundKey(stageKeys[i-1][i]),
      .keysIn(stageKeys[i-1]),
      .out(stageState[i]),
      .keysOut(stageKeys[i])
    );
  end

  FillCounter #(.NUM_ROUNDS(NUM_ROUNDS)) fill (
    .clock(clock),
    .rst(rst),
    .valid(valid)
  );

  assign out = stageState[NUM_ROUNDS];

endmodule

// File: design/AESDecoder.sv
// Fully pipelined AES decryption using the inverse cipher
// Round keys are applied last to first, same latency as the encoder

`timescale 1ns/1ps

module AESDecoder
  import AESDefinitions::*;
#(
  parameter int KEY_SIZE = 128,
  parameter type key_t = byte_t [0:KEY_SIZE/8-1]
)
(
  input logic clock,
  input logic rst,
  input state_t in,
  input key_t key,
  output state_t out,
  output logic valid
);

  localparam int NUM_ROUNDS = numRounds(KEY_SIZE);

  typedef roundKey_t [0:NUM_ROUNDS] roundKeys_t;

  state_t stageState [NUM_ROUNDS+1];
  roundKeys_t stageKeys [NUM_ROUNDS+1];

  ExpandKey #(
    .KEY_SIZE(KEY_SIZE),
    .NUM_ROUNDS(NUM_ROUNDS),
    .key_t(key_t),
    .roundKeys_t(roundKeys_t)
  ) keyExpansion (
    .key(key),
    .roundKeys(stageKeys[0])
  );

  // Decryption starts from the final round key
  assign stageState[0] = in ^ stageKeys[0][NUM_ROUNDS];

  for (genvar i = 1; i <= NUM_ROUNDS; i++)
  begin : genRounds
    AESRound #(
      .ROUND(i),
      .NUM_ROUNDS(NUM_ROUNDS),
      .INVERSE(1'b1),
      .keys_t(roundKeys_t)
    ) round (
      .clock(clock),
      .rst(rst),
      .in(stageState[i-1]),
      .roundKey(stageKeys[i-1][NUM_ROUNDS-i]),
      .keysIn(stageKeys[i-1]),
      .out(stageState[i]),
      .keysOut(stageKeys[i])
    );
  end

  FillCounter #(.NUM_ROUNDS(NUM_ROUNDS)) fill (
    .clock(clock),
    .rst(rst),
    .valid(valid)
  );

  assign out = stageState[NUM_ROUNDS];

endmodule

// File: design/AESCore.sv
// AES core top level with independent encrypt and decrypt pipelines
// KEY_SIZE picks AES-128, AES-192 or AES-256 for both sides

`timescale 1ns/1ps

module AESCore
  import AESDefinitions::*;
#(
  parameter int KEY_SIZE = 128,
  parameter type key_t = byte_t [0:KEY_SIZE/8-1]
)
(
  input logic clock,
  input logic rst,
  input state_t encIn,
  input key_t encKey,
  output state_t encOut,
  output logic encValid,
  input state_t decIn,
  input key_t decKey,
  output state_t decOut,
  output logic decValid
);

  AESEncoder #(.KEY_SIZE(KEY_SIZE), .key_t(key_t)) encoder (
    .clock(clock),
    .rst(rst),
    .in(encIn),
    .key(encKey),
    .out(encOut),
    .valid(encValid)
  );

  AESDecoder #(.KEY_SIZE(KEY_SIZE), .key_t(key_t)) decoder (
    .clock(clock),
    .rst(rst),
    .in(decIn),
    .key(decKey),
    .out(decOut),
    .valid(decValid)
  );

endmodule

// File: tests/AESModel.svh
// Reference AES model, LFSR and FIPS-197 known-answer vectors for the testbench
// Included inside the testbench module, which supplies KEY_SIZE, NR and key_t

`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

typedef logic [0:59][31:0] schedule_t;

byte_t sTable [256];
byte_t invTable [256];
logic [31:0] lfsrState = 32'hf95b4b95;

// Appendix C plaintext, same for every key size
localparam state_t KAT_PLAIN = 128'h00112233445566778899aabbccddeeff;

function automatic state_t katCipher();
  case (KEY_SIZE)
    192: return 128'hdda97ca4864cdfe06eaf70a0ec0d7191;
    256: return 128'h8ea2b7ca516745bfeafc49904b496089;
    default: return 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  endcase
endfunction

// Appendix C keys count up from zero
function automatic key_t katKey();
  key_t k;
  for (int i = 0; i < KEY_BYTES; i++)
    k[i] = 8'(i);
  return k;
endfunction

// Galois LFSR, one step per bit taken
function automatic logic nextBit();
  logic bitOut;
  bitOut = lfsrState[0];
  lfsrState = {1'b0, lfsrState[31:1]} ^ (bitOut ? 32'h80200003 : 32'h00000000);
  return bitOut;
endfunction

function automatic byte_t randomByte();
  byte_t b;
  b = 8'h00;
  for (int i = 0; i < 8; i++)
    b = {b[6:0], nextBit()};
  return b;
endfunction

function automatic state_t randomState();
  state_t s;
  for (int i = 0; i < 16; i++)
    s[i] = randomByte();
  return s;
endfunction

function automatic key_t randomKey();
  key_t k;
  for (int i = 0; i < KEY_BYTES; i++)
    k[i] = randomByte();
  return k;
endfunction

// Polynomial product, then reduction by 0x11b from the top bit down
function automatic byte_t fieldMul(byte_t a, byte_t b);
  logic [14:0] wide;
  wide = '0;
  for (int i = 0; i < 8; i++)
    if (b[i])
      wide = wide ^ (15'(a) << i);
  for (int i = 14; i >= 8; i--)
    if (wide[i])
      wide = wide ^ (15'h11b << (i - 8));
  return wide[7:0];
endfunction

// S-box from the field inverse and the affine map
function automatic void buildTables();
  byte_t inv;
  byte_t s;
  for (int x = 0; x < 256; x++)
  begin
    inv = 8'h01;
    for (int i = 0; i < 254; i++)
      inv = fieldMul(inv, 8'(x));
    s = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
      ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    sTable[x] = s;
    invTable[s] = 8'(x);
  end
endfunction

function automatic schedule_t keySchedule(key_t key);
  schedule_t w;
  logic [31:0] t;
  byte_t rc;
  w = '0;
  rc = 8'h01;
  for (int i = 0; i < KEY_SIZE / 32; i++)
    w[i] = {key[4*i], key[4*i+1], key[4*i+2], key[4*i+3]};
  for (int i = KEY_SIZE / 32; i < 4 * (NR + 1); i++)
  begin
    t = w[i-1];
    if (i % (KEY_SIZE / 32) == 0)
    begin
      t = {sTable[t[23:16]], sTable[t[15:8]], sTable[t[7:0]], sTable[t[31:24]]}
        ^ {rc, 24'h000000};
      rc = fieldMul(rc, 8'h02);
    end
    else if (KEY_SIZE == 256 && i % 8 == 4)
      t = {sTable[t[31:24]], sTable[t[23:16]], sTable[t[15:8]], sTable[t[7:0]]};
    w[i] = w[i-KEY_SIZE/32] ^ t;
  end
  return w;
endfunction

function automatic state_t addKey(state_t s, schedule_t w, int round);
  state_t t;
  for (int c = 0; c < 4; c++)
    for (int b = 0; b < 4; b++)
      t[4*c+b] = s[4*c+b] ^ w[4*round+c][31-8*b -: 8];
  return t;
endfunction

function automatic state_t substitute(state_t s, bit inverse);
  state_t t;
  for (int i = 0; i < 16; i++)
    t[i] = inverse ? invTable[s[i]] : sTable[s[i]];
  return t;
endfunction

// Row r rotates left by r, or right by r for the inverse
function automatic state_t rotateRows(state_t s, bit inverse);
  state_t t;
  int src;
  for (int c = 0; c < 4; c++)
    for (int r = 0; r < 4; r++)
    begin
      src = inverse ? (c + 4 - r) % 4 : (c + r) % 4;
      t[r+4*c] = s[r+4*src];
    end
  return t;
endfunction

// Circulant column mix, coef holds the first matrix row
function automatic state_t mixWith(state_t s, logic [31:0] coef);
  state_t t;
  byte_t acc;
  for (int c = 0; c < 4; c++)
    for (int r = 0; r < 4; r++)
    begin
      acc = 8'h00;
      for (int k = 0; k < 4; k++)
        acc = acc ^ fieldMul(coef[31-8*((k-r+4)%4) -: 8], s[k+4*c]);
      t[r+4*c] = acc;
    end
  return t;
endfunction

function automatic state_t aesEncrypt(state_t block, key_t key);
  schedule_t w;
  state_t s;
  w = keySchedule(key);
  s = addKey(block, w, 0);
  for (int r = 1; r <= NR; r++)
  begin
    s = rotateRows(substitute(s, 1'b0), 1'b0);
    if (r < NR)
      s = mixWith(s, 32'h02030101);
    s = addKey(s, w, r);
  end
  return s;
endfunction

function automatic state_t aesDecrypt(state_t block, key_t key);
  schedule_t w;
  state_t s;
  w = keySchedule(key);
  s = addKey(block, w, NR);
  for (int r = NR - 1; r >= 0; r--)
  begin
    s = substitute(rotateRows(s, 1'b1), 1'b1);
    s = addKey(s, w, r);
    if (r > 0)
      s = mixWith(s, 32'h0e0b0d09);
  end
  return s;
endfunction

`endif

// File: tests/AESCore_tb.sv
// Testbench for the AES core with known answers, full-rate random traffic and round trips
// KEY_SIZE selects the cipher variant and results are scored against the included model

`timescale 1ns/1ps

module AESCore_tb
  import AESDefinitions::*;
#(
  parameter int KEY_SIZE = 128
);

  localparam int NR = KEY_SIZE / 32 + 6;
  localparam int KEY_BYTES = KEY_SIZE / 8;
  localparam int TIMEOUT_CYCLES = 100;
  localparam int RANDOM_CYCLES = 200;
  localparam int TRIP_BLOCKS = 100;

  typedef byte_t [0:KEY_BYTES-1] key_t;

  `include "AESModel.svh"

  logic clock = 1'b0;
  logic rst;
  state_t encIn;
  key_t encKey;
  state_t encOut;
  logic encValid;
  state_t decIn;
  key_t decKey;
  state_t decOut;
  logic decValid;

  // Scoreboard entries carry the edge after which each result is due
  int encDue [$];
  state_t encExp [$];
  int decDue [$];
  state_t decExp [$];
  int edgeCount = 0;
  int lowEdges = 0;
  int checkCount = 0;
  int errorCount = 0;
  bit timedOut = 1'b0;

  AESCore #(.KEY_SIZE(KEY_SIZE), .key_t(key_t)) uut (
    .clock(clock),
    .rst(rst),
    .encIn(encIn),
    .encKey(encKey),
    .encOut(encOut),
    .encValid(encValid),
    .decIn(decIn),
    .decKey(decKey),
    .decOut(decOut),
    .decValid(decValid)
  );

  always #5 clock = ~clock;

  task automatic checkState(string name, state_t expected, state_t actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic checkValid(string name, logic expected, logic actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("ERR t=%0t %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  // Driven just after a falling edge so the result shows after edge edgeCount+NR
  task automatic driveEncoder(state_t block, key_t key, state_t expected);
    encIn = block;
    encKey = key;
    encDue.push_back(edgeCount + NR);
    encExp.push_back(expected);
  endtask

  task automatic driveDecoder(state_t block, key_t key, state_t expected);
    decIn = block;
    decKey = key;
    decDue.push_back(edgeCount + NR);
    decExp.push_back(expected);
  endtask

  task automatic waitForValid();
    int waited;
    waited = 0;
    while (!(encValid && decValid) && waited < TIMEOUT_CYCLES)
    begin
      @(negedge clock);
      waited++;
    end
    if (!(encValid && decValid))
    begin
      $display("Timeout: valid did not rise within %0d cycles of reset", TIMEOUT_CYCLES);
      timedOut = 1'b1;
    end
  endtask

  task automatic waitDrained(string testName);
    int waited;
    waited = 0;
    while ((encDue.size() > 0 || decDue.size() > 0) && waited < TIMEOUT_CYCLES)
    begin
      @(negedge clock);
      waited++;
    end
    if (encDue.size() > 0 || decDue.size() > 0)
    begin
      $display("Timeout in %s: results still outstanding after %0d cycles",
               testName, TIMEOUT_CYCLES);
      timedOut = 1'b1;
    end
  endtask

  task automatic reportTest(string testName, int checksBefore, int errorsBefore);
    $display("Test %s finished: %0d checks, %0d errors", testName,
             checkCount - checksBefore, errorCount - errorsBefore);
  endtask

  task automatic resetAndFill();
    int checksBefore;
    int errorsBefore;
    checksBefore = checkCount;
    errorsBefore = errorCount;
    repeat (4) @(negedge clock);
    rst = 1'b0;
    waitForValid();
    reportTest("reset and fill", checksBefore, errorsBefore);
  endtask

  task automatic knownAnswer();
    int checksBefore;
    int errorsBefore;
    key_t key;
    checksBefore = checkCount;
    errorsBefore = errorCount;
    key = katKey();
    checkCount++;
    if (aesEncrypt(KAT_PLAIN, key) !== katCipher())
    begin
      errorCount++;
      $display("Reference model does not reproduce the published AES-%0d ciphertext",
               KEY_SIZE);
    end
    @(negedge clock);
    driveEncoder(KAT_PLAIN, key, katCipher());
    driveDecoder(katCipher(), key, KAT_PLAIN);
    waitDrained("known answer");
    reportTest("known answer", checksBefore, errorsBefore);
  endtask

  task automatic randomEncryption();
    int checksBefore;
    int errorsBefore;
    state_t block;
    key_t key;
    checksBefore = checkCount;
    errorsBefore = errorCount;
    repeat (RANDOM_CYCLES)
    begin
      @(negedge clock);
      block = randomState();
      key = randomKey();
      driveEncoder(block, key, aesEncrypt(block, key));
    end
    waitDrained("random encryption");
    reportTest("random encryption", checksBefore, errorsBefore);
  endtask

  task automatic randomDecryption();
    int checksBefore;
    int errorsBefore;
    state_t block;
    key_t key;
    checksBefore = checkCount;
    errorsBefore = errorCount;
    repeat (RANDOM_CYCLES)
    begin
      @(negedge clock);
      block = randomState();
      key = randomKey();
      driveDecoder(block, key, aesDecrypt(block, key));
    end
    waitDrained("random decryption");
    reportTest("random decryption", checksBefore, errorsBefore);
  endtask

  // Each ciphertext goes back in with the key of its own block
  task automatic roundTrip();
    int checksBefore;
    int errorsBefore;
    state_t block;
    key_t key;
    state_t pendPlain [$];
    key_t pendKey [$];
    checksBefore = checkCount;
    errorsBefore = errorCount;
    for (int c = 0; c < TRIP_BLOCKS + NR; c++)
    begin
      @(negedge clock);
      if (c < TRIP_BLOCKS)
      begin
        block = randomState();
        key = randomKey();
        driveEncoder(block, key, aesEncrypt(block, key));
        pendPlain.push_back(block);
        pendKey.push_back(key);
      end
      if (c >= NR)
        driveDecoder(encOut, pendKey.pop_front(), pendPlain.pop_front());
    end
    waitDrained("round trip");
    reportTest("round trip", checksBefore, errorsBefore);
  endtask

  // Compare just after each rising edge once the registered outputs have settled
  initial
  begin
    forever
    begin
      @(posedge clock);
      #1;
      edgeCount++;
      if (rst)
        lowEdges = 0;
      else
        lowEdges++;
      checkValid("encValid", lowEdges >= NR, encValid);
      checkValid("decValid", lowEdges >= NR, decValid);
      while (encDue.size() > 0 && encDue[0] == edgeCount)
      begin
        checkState("encOut", encExp.pop_front(), encOut);
        void'(encDue.pop_front());
      end
      while (decDue.size() > 0 && decDue[0] == edgeCount)
      begin
        checkState("decOut", decExp.pop_front(), decOut);
        void'(decDue.pop_front());
      end
    end
  end

  initial
  begin
    rst = 1'b1;
    encIn = '0;
    encKey = '0;
    decIn = '0;
    decKey = '0;
    buildTables();

    resetAndFill();
    if (!timedOut)
      knownAnswer();
    if (!timedOut)
      randomEncryption();
    if (!timedOut)
      randomDecryption();
    if (!timedOut)
      roundTrip();

    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0 && !timedOut)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: AESCore.f
+incdir+tests
common/AESDefinitions.sv
keyexpand/ExpandKey.sv
rounds/AESRound.sv
design/FillCounter.sv
design/AESEncoder.sv
design/AESDecoder.sv
design/AESCore.sv
tests/AESCore_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the AES core testbench with Verilator for every key size
set -e
cd "$(dirname "$0")"

status=0
for ks in 128 192 256; do
  verilator --binary --timing --assert -f AESCore.f --top-module AESCore_tb \
    -GKEY_SIZE=$ks --Mdir build_$ks -o sim
  output=$(./build_$ks/sim)
  echo "$output"
  if ! grep -qx "All checks passed" <<< "$output"; then
    echo "AES-$ks run did not pass"
    status=1
  fi
done
exit $status
